/* Bender.yml */
package:
  name: ooo_issue

sources:
  - files:
      - rtl/ooo_pkg.sv
      - rtl/rs.sv
      - rtl/exec_lanes.sv
      - rtl/ooo_issue_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/ooo_issue_asserts.sv
      - dv/tb_ooo_issue.sv

/* dv/ooo_issue_asserts.sv */
//####################################################################
// Concurrent checks on issue and retire outputs, bound into the top.
// fail_count is read by the testbench to end the run on a failure.
//####################################################################

`timescale 1ns/10ps

module ooo_issue_asserts (
	input logic               clock,
	input logic               rst_n,
	input logic               flush,
	input logic               issue_en,
	input logic               cdb_en,
	input logic               remove_en,
	input ooo_pkg::slot_idx_t remove_slot
);

	int unsigned fail_count = 0;

	// A lane retires once and is idle on the next cycle
	a_single_remove: assert property (@(posedge clock) disable iff (!rst_n)
		remove_en |=> !(remove_en && (remove_slot == $past(remove_slot))))
	else begin
		fail_count++;
		$error("remove_en repeated for slot %0d", remove_slot);
	end

	// Every broadcast belongs to a retiring op
	a_cdb_with_remove: assert property (@(posedge clock) disable iff (!rst_n)
		cdb_en |-> remove_en)
	else begin
		fail_count++;
		$error("cdb_en high without remove_en");
	end

	a_quiet_after_clear: assert property (@(posedge clock)
		(!rst_n || flush) |=> (!issue_en && !remove_en))
	else begin
		fail_count++;
		$error("issue_en or remove_en high right after reset or flush");
	end

endmodule

bind ooo_issue_top ooo_issue_asserts i_asserts (.clock, .rst_n, .flush, .issue_en,
	.cdb_en, .remove_en, .remove_slot);

/* dv/tb_clock_gen.sv */
//####################################################################
// Testbench clock, 10 ns period, rst_n held low for 8 rising edges.
//####################################################################

`timescale 1ns/10ps

module tb_clock_gen (
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clock);
		rst_n <= 1'b1;
	end

endmodule

/* dv/tb_ooo_issue.sv */
//####################################################################
// Testbench for ooo_issue_top with a reference model of the station.
// Directed spill, wakeup and bypass cases, random traffic, then flush.
//####################################################################

`timescale 1ns/10ps

module tb_ooo_issue;

	localparam int MULT_LAT = 4;
	localparam int TIMEOUT  = 200;

	logic                 clock;
	logic                 rst_n;
	logic                 flush;
	logic                 dispatch_en;
	ooo_pkg::decoded_op_t dispatch_op;
	logic                 dispatch_ready;
	logic                 issue_en;
	ooo_pkg::issue_pkt_t  issue_pkt;
	logic                 cdb_en;
	ooo_pkg::cdb_t        cdb;
	logic                 remove_en;
	ooo_pkg::slot_idx_t   remove_slot;

	// Model state, owned by the compare process
	logic [ooo_pkg::RS_SLOTS-1:0] m_busy;
	logic [ooo_pkg::RS_SLOTS-1:0] m_iss;
	logic [ooo_pkg::RS_SLOTS-1:0] busy_seen;
	ooo_pkg::decoded_op_t         m_op   [ooo_pkg::RS_SLOTS];
	int                           m_icyc [ooo_pkg::RS_SLOTS];
	int                           m_out  [64];
	int                           cycle       = 0;
	int                           wake_hits   = 0;
	int                           bypass_hits = 0;

	tb_clock_gen i_clock_gen (.clock(clock), .rst_n(rst_n));

	ooo_issue_top #(.MULT_LATENCY(MULT_LAT)) i_dut (.*);

	// ALU 0, load 1, store 2, multiply 3 or 4 when 3 is taken
	function automatic ooo_pkg::slot_idx_t exp_slot(input ooo_pkg::op_class_t cls,
			input logic [ooo_pkg::RS_SLOTS-1:0] busy);
		if (cls == ooo_pkg::CLASS_MULT) begin
			return busy[3] ? 3'd4 : 3'd3;
		end
		return ooo_pkg::slot_idx_t'(cls);
	endfunction

	function automatic int latency(input ooo_pkg::op_class_t cls);
		case (cls)
			ooo_pkg::CLASS_LOAD: return 2;
			ooo_pkg::CLASS_MULT: return MULT_LAT;
			default:             return 1;
		endcase
	endfunction

	function automatic logic opnd_ok(input ooo_pkg::operand_t o);
		return !o.valid || o.ready;
	endfunction

	// Only t1 is used, dest always valid
	function automatic ooo_pkg::decoded_op_t make_op(input ooo_pkg::op_class_t cls,
			input logic src_valid, input ooo_pkg::phys_reg_t src, input ooo_pkg::phys_reg_t dest);
		ooo_pkg::decoded_op_t op;
		op            = '0;
		op.op_class   = cls;
		op.t1.valid   = src_valid;
		op.t1.tag     = src;
		op.dest_valid = 1'b1;
		op.dest_tag   = dest;
		return op;
	endfunction

	// Random op with ready sources, so it never waits forever
	function automatic ooo_pkg::decoded_op_t rand_op();
		logic [31:0]          r;
		ooo_pkg::decoded_op_t op;
		r           = $urandom;
		op          = r[$bits(ooo_pkg::decoded_op_t)-1:0];
		op.t1.ready = 1'b1;
		op.t2.ready = 1'b1;
		return op;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			stop_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, want));
		end
	endtask

	task automatic check_slot(input string name, input ooo_pkg::slot_idx_t got,
			input ooo_pkg::slot_idx_t want);
		if (got !== want) begin
			stop_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, want));
		end
	endtask

	task automatic check_tag(input string name, input ooo_pkg::phys_reg_t got,
			input ooo_pkg::phys_reg_t want);
		if (got !== want) begin
			stop_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, want));
		end
	endtask

	task automatic wake_operand(inout ooo_pkg::operand_t o, input ooo_pkg::phys_reg_t tag,
			inout int hits);
		if (o.valid && !o.ready && (o.tag == tag)) begin
			o.ready = 1'b1;
			hits++;
		end
	endtask

	// Hold one op on the dispatch port until it is taken
	task automatic send_op(input ooo_pkg::decoded_op_t op);
		int n;
		dispatch_en <= 1'b1;
		dispatch_op <= op;
		n = 0;
		do begin
			@(posedge clock);
			n++;
		end while (!dispatch_ready && n < TIMEOUT);
		if (!dispatch_ready) begin
			stop_run("Timeout waiting for dispatch_ready");
		end
		dispatch_en <= 1'b0;
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		do begin
			@(posedge clock);
			n++;
		end while (busy_seen != '0 && n < TIMEOUT);
		if (busy_seen != '0) begin
			stop_run("Reservation station did not drain before the timeout");
		end
	endtask

	// Check the DUT at every edge, then advance the model
	always @(posedge clock) begin : compare
		ooo_pkg::slot_idx_t   exp_s;
		ooo_pkg::slot_idx_t   exp_is;
		ooo_pkg::slot_idx_t   exp_rs;
		ooo_pkg::decoded_op_t op;
		logic                 exp_dr;
		logic                 exp_ie;
		logic                 exp_re;
		logic                 exp_ce;
		cycle++;
		if (i_dut.i_asserts.fail_count != 0) begin
			stop_run("A bound assertion failed");
		end
		if (!rst_n || flush) begin
			m_busy = '0;
			m_iss  = '0;
			for (int t = 0; t < 64; t++) begin
				m_out[t] = 0;
			end
		end else begin
			exp_s  = exp_slot(dispatch_op.op_class, m_busy);
			exp_dr = !m_busy[exp_s];
			check_flag("dispatch_ready", dispatch_ready, exp_dr);
			exp_ie = 1'b0;
			exp_is = '0;
			for (int s = 0; s < ooo_pkg::RS_SLOTS; s++) begin
				if (m_busy[s] && !m_iss[s] && opnd_ok(m_op[s].t1) && opnd_ok(m_op[s].t2)) begin
					exp_ie = 1'b1;
					exp_is = ooo_pkg::slot_idx_t'(s);
				end
			end
			check_flag("issue_en", issue_en, exp_ie);
			if (exp_ie) begin
				check_slot("issue_pkt.slot", issue_pkt.slot, exp_is);
				check_tag("issue_pkt.op.dest_tag", issue_pkt.op.dest_tag, m_op[exp_is].dest_tag);
			end
			// Lowest numbered op past its latency retires
			exp_re = 1'b0;
			exp_rs = '0;
			for (int s = ooo_pkg::RS_SLOTS - 1; s >= 0; s--) begin
				if (m_iss[s] && (cycle - m_icyc[s] >= latency(m_op[s].op_class))) begin
					exp_re = 1'b1;
					exp_rs = ooo_pkg::slot_idx_t'(s);
				end
			end
			exp_ce = exp_re && m_op[exp_rs].dest_valid;
			check_flag("remove_en", remove_en, exp_re);
			check_flag("cdb_en", cdb_en, exp_ce);
			if (exp_re) begin
				check_slot("remove_slot", remove_slot, exp_rs);
				m_busy[exp_rs] = 1'b0;
				m_iss[exp_rs]  = 1'b0;
			end
			if (exp_ce) begin
				if (m_out[cdb.tag] == 0) begin
					stop_run("CDB broadcast a tag with no producer outstanding");
				end
				check_tag("cdb.tag", cdb.tag, m_op[exp_rs].dest_tag);
				m_out[cdb.tag]--;
				for (int s = 0; s < ooo_pkg::RS_SLOTS; s++) begin
					if (m_busy[s]) begin
						wake_operand(m_op[s].t1, cdb.tag, wake_hits);
						wake_operand(m_op[s].t2, cdb.tag, wake_hits);
					end
				end
			end
			if (exp_ie) begin
				m_iss[exp_is]  = 1'b1;
				m_icyc[exp_is] = cycle;
			end
			if (dispatch_en && exp_dr) begin
				op = dispatch_op;
				if (exp_ce) begin
					wake_operand(op.t1, cdb.tag, bypass_hits);
					wake_operand(op.t2, cdb.tag, bypass_hits);
				end
				m_op[exp_s]   = op;
				m_busy[exp_s] = 1'b1;
				if (op.dest_valid) begin
					m_out[op.dest_tag]++;
				end
			end
		end
		busy_seen <= m_busy;
	end

	initial begin : stimulus
		int n;
		void'($urandom(32'hc199_6071));
		flush       <= 1'b0;
		dispatch_en <= 1'b0;
		dispatch_op <= '0;
		n = 0;
		while (!rst_n && n < TIMEOUT) begin
			@(posedge clock);
			n++;
		end
		if (!rst_n) begin
			stop_run("Reset was never released");
		end
		// Second multiply spills into slot 4
		send_op(make_op(ooo_pkg::CLASS_MULT, 1'b0, 6'h00, 6'h10));
		send_op(make_op(ooo_pkg::CLASS_MULT, 1'b0, 6'h00, 6'h11));
		wait_drained();
		// ALU op waits for the multiply result
		send_op(make_op(ooo_pkg::CLASS_MULT, 1'b0, 6'h00, 6'h2a));
		send_op(make_op(ooo_pkg::CLASS_ALU, 1'b1, 6'h2a, 6'h2b));
		wait_drained();
		// ALU issues one edge after dispatch and broadcasts on the next,
		// the load lands on that same edge
		send_op(make_op(ooo_pkg::CLASS_ALU, 1'b0, 6'h00, 6'h35));
		@(posedge clock);
		send_op(make_op(ooo_pkg::CLASS_LOAD, 1'b1, 6'h35, 6'h36));
		wait_drained();
		repeat (400) begin
			dispatch_en <= ($urandom % 4) != 0;
			dispatch_op <= rand_op();
			@(posedge clock);
		end
		dispatch_en <= 1'b0;
		wait_drained();
		// Fill the station, then flush with ops in flight
		repeat (6) begin
			dispatch_en <= 1'b1;
			dispatch_op <= rand_op();
			@(posedge clock);
		end
		dispatch_en <= 1'b0;
		flush       <= 1'b1;
		@(posedge clock);
		flush <= 1'b0;
		for (int c = 0; c < 4; c++) begin
			dispatch_op.op_class <= ooo_pkg::op_class_t'(c);
			@(posedge clock);
		end
		repeat (10) @(posedge clock);
		if (wake_hits == 0 || bypass_hits == 0) begin
			stop_run("No CDB wakeup or no dispatch bypass happened");
		end
		if (i_dut.i_asserts.fail_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* rtl/exec_lanes.sv */
//####################################################################
// One latency lane per slot, lowest done lane retires each cycle.
// MULT_LATENCY must lie between 2 and 7.
//####################################################################

`timescale 1ns/10ps

module exec_lanes #(
	parameter int MULT_LATENCY = 3
) (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                flush,
	input  logic                issue_en,
	input  ooo_pkg::issue_pkt_t issue_pkt,
	output logic                cdb_en,
	output ooo_pkg::cdb_t       cdb,
	output logic                remove_en,
	output ooo_pkg::slot_idx_t  remove_slot
);

	localparam int ALU_LATENCY   = 1;
	localparam int LOAD_LATENCY  = 2;
	localparam int STORE_LATENCY = 1;

	typedef logic [2:0] lat_cnt_t;

	logic [ooo_pkg::RS_SLOTS-1:0] active;
	logic [ooo_pkg::RS_SLOTS-1:0] done;
	logic [ooo_pkg::RS_SLOTS-1:0] dest_valid;
	lat_cnt_t                     count    [ooo_pkg::RS_SLOTS];
	ooo_pkg::phys_reg_t           dest_tag [ooo_pkg::RS_SLOTS];

	// Counter start value, one below the class latency
	function automatic lat_cnt_t first_count(input ooo_pkg::op_class_t cls);
		case (cls)
			ooo_pkg::CLASS_ALU:   return lat_cnt_t'(ALU_LATENCY - 1);
			ooo_pkg::CLASS_LOAD:  return lat_cnt_t'(LOAD_LATENCY - 1);
			ooo_pkg::CLASS_STORE: return lat_cnt_t'(STORE_LATENCY - 1);
			default:              return lat_cnt_t'(MULT_LATENCY - 1);
		endcase
	endfunction

	always_comb begin
		for (int i = 0; i < ooo_pkg::RS_SLOTS; i++) begin
			done[i] = active[i] && (count[i] == '0);
		end
	end

	// Lowest numbered done lane retires, others hold
	always_comb begin
		remove_en   = 1'b0;
		remove_slot = '0;
		cdb_en      = 1'b0;
		cdb         = '0;
		for (int i = ooo_pkg::RS_SLOTS - 1; i >= 0; i--) begin
			if (done[i]) begin
				remove_en   = 1'b1;
				remove_slot = ooo_pkg::slot_idx_t'(i);
				cdb_en      = dest_valid[i];
				cdb.tag     = dest_tag[i];
			end
		end
	end

	// Lane occupancy
	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			active <= '0;
		end else begin
			if (remove_en) begin
				active[remove_slot] <= 1'b0;
			end
			if (issue_en) begin
				active[issue_pkt.slot] <= 1'b1;
			end
		end
	end

	// Countdown and destination payload
	always_ff @(posedge clock) begin
		for (int i = 0; i < ooo_pkg::RS_SLOTS; i++) begin
			if (count[i] != '0) begin
				count[i] <= count[i] - 3'd1;
			end
		end
		if (issue_en) begin
			count[issue_pkt.slot]      <= first_count(issue_pkt.op.op_class);
			dest_valid[issue_pkt.slot] <= issue_pkt.op.dest_valid;
			dest_tag[issue_pkt.slot]   <= issue_pkt.op.dest_tag;
		end
	end

endmodule

/* rtl/ooo_issue_top.sv */
//####################################################################
// Issue window top, reservation station plus execution lanes.
//####################################################################

`timescale 1ns/10ps

module ooo_issue_top #(
	parameter int MULT_LATENCY = 3
) (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 flush,
	input  logic                 dispatch_en,
	input  ooo_pkg::decoded_op_t dispatch_op,
	output logic                 dispatch_ready,
	output logic                 issue_en,
	output ooo_pkg::issue_pkt_t  issue_pkt,
	output logic                 cdb_en,
	output ooo_pkg::cdb_t        cdb,
	output logic                 remove_en,
	output ooo_pkg::slot_idx_t   remove_slot
);

	// Table, wakeup and issue select
	rs i_rs (
		.clock          (clock),
		.rst_n          (rst_n),
		.flush          (flush),
		.dispatch_en    (dispatch_en),
		.dispatch_op    (dispatch_op),
		.dispatch_ready (dispatch_ready),
		.cdb_en         (cdb_en),
		.cdb            (cdb),
		.remove_en      (remove_en),
		.remove_slot    (remove_slot),
		.issue_en       (issue_en),
		.issue_pkt      (issue_pkt)
	);

	// Latency countdown and completion arbitration
	exec_lanes #(
		.MULT_LATENCY (MULT_LATENCY)
	) i_exec_lanes (
		.clock       (clock),
		.rst_n       (rst_n),
		.flush       (flush),
		.issue_en    (issue_en),
		.issue_pkt   (issue_pkt),
		.cdb_en      (cdb_en),
		.cdb         (cdb),
		.remove_en   (remove_en),
		.remove_slot (remove_slot)
	);

endmodule

/* rtl/ooo_pkg.sv */
//####################################################################
// Shared widths, class codes and packets for the issue window.
// RS_SLOTS is fixed at 5 since every slot is tied to one unit class.
//####################################################################

package ooo_pkg;

	// Tag, slot and code widths
	typedef logic [5:0] phys_reg_t;
	typedef logic [2:0] slot_idx_t;
	typedef logic [1:0] op_class_t;
	typedef logic [3:0] alu_func_t;

	// Functional unit classes
	localparam op_class_t CLASS_ALU   = 2'd0;
	localparam op_class_t CLASS_LOAD  = 2'd1;
	localparam op_class_t CLASS_STORE = 2'd2;
	localparam op_class_t CLASS_MULT  = 2'd3;

	// Slot 0 ALU, 1 load, 2 store, 3 and 4 multiply
	localparam int RS_SLOTS = 5;

	// One source operand, only the tag and its ready bit
	typedef struct packed {
		logic      valid;
		logic      ready;
		phys_reg_t tag;
	} operand_t;

	// Decoded op as written by the decoder
	typedef struct packed {
		op_class_t op_class;
		alu_func_t alu_func;
		operand_t  t1;
		operand_t  t2;
		logic      dest_valid;
		phys_reg_t dest_tag;
	} decoded_op_t;

	// Issued op with the slot it came from
	typedef struct packed {
		decoded_op_t op;
		slot_idx_t   slot;
	} issue_pkt_t;

	// CDB payload, enable travels beside it
	typedef struct packed {
		phys_reg_t tag;
	} cdb_t;

endpackage

/* rtl/rs.sv */
//####################################################################
// Five-entry reservation station, one slot per unit class.
// A slot may not be freed and refilled in the same cycle.
//####################################################################

`timescale 1ns/10ps

module rs (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 flush,
	input  logic                 dispatch_en,
	input  ooo_pkg::decoded_op_t dispatch_op,
	output logic                 dispatch_ready,
	input  logic                 cdb_en,
	input  ooo_pkg::cdb_t        cdb,
	input  logic                 remove_en,
	input  ooo_pkg::slot_idx_t   remove_slot,
	output logic                 issue_en,
	output ooo_pkg::issue_pkt_t  issue_pkt
);

	logic [ooo_pkg::RS_SLOTS-1:0] busy;
	logic [ooo_pkg::RS_SLOTS-1:0] issued;
	logic [ooo_pkg::RS_SLOTS-1:0] eligible;
	ooo_pkg::decoded_op_t         entry_op [ooo_pkg::RS_SLOTS];

	ooo_pkg::slot_idx_t   disp_slot;
	ooo_pkg::decoded_op_t disp_op_byp;
	logic                 disp_fire;

	// Set ready when a valid operand matches the broadcast tag
	function automatic ooo_pkg::operand_t wake(
		input ooo_pkg::operand_t  opnd,
		input logic               en,
		input ooo_pkg::phys_reg_t tag
	);
		ooo_pkg::operand_t res;
		res = opnd;
		if (en && opnd.valid && (opnd.tag == tag)) begin
			res.ready = 1'b1;
		end
		return res;
	endfunction

	// Dispatch slot from class, second multiply spills into slot 4
	always_comb begin
		case (dispatch_op.op_class)
			ooo_pkg::CLASS_ALU:   disp_slot = 3'd0;
			ooo_pkg::CLASS_LOAD:  disp_slot = 3'd1;
			ooo_pkg::CLASS_STORE: disp_slot = 3'd2;
			default:              disp_slot = busy[3] ? 3'd4 : 3'd3;
		endcase
	end

	assign dispatch_ready = !busy[disp_slot];
	assign disp_fire      = dispatch_en && dispatch_ready;

	// Bypass a broadcast into the op being written this cycle
	always_comb begin
		disp_op_byp    = dispatch_op;
		disp_op_byp.t1 = wake(dispatch_op.t1, cdb_en, cdb.tag);
		disp_op_byp.t2 = wake(dispatch_op.t2, cdb_en, cdb.tag);
	end

	// Busy, not issued, all used sources ready
	always_comb begin
		for (int i = 0; i < ooo_pkg::RS_SLOTS; i++) begin
			eligible[i] = busy[i] && !issued[i] &&
				(!entry_op[i].t1.valid || entry_op[i].t1.ready) &&
				(!entry_op[i].t2.valid || entry_op[i].t2.ready);
		end
	end

	// Highest numbered eligible slot wins
	always_comb begin
		issue_en  = 1'b0;
		issue_pkt = '0;
		for (int i = 0; i < ooo_pkg::RS_SLOTS; i++) begin
			if (eligible[i]) begin
				issue_en       = 1'b1;
				issue_pkt.op   = entry_op[i];
				issue_pkt.slot = ooo_pkg::slot_idx_t'(i);
			end
		end
	end

	// Occupancy and issue state
	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			busy   <= '0;
			issued <= '0;
		end else begin
			if (issue_en) begin
				issued[issue_pkt.slot] <= 1'b1;
			end
			if (disp_fire) begin
				busy[disp_slot] <= 1'b1;
			end
			// Remove only hits an issued slot, never the dispatch slot
			if (remove_en) begin
				busy[remove_slot]   <= 1'b0;
				issued[remove_slot] <= 1'b0;
			end
		end
	end

	// Entry payload and CDB wakeup
	always_ff @(posedge clock) begin
		for (int i = 0; i < ooo_pkg::RS_SLOTS; i++) begin
			entry_op[i].t1 <= wake(entry_op[i].t1, cdb_en, cdb.tag);
			entry_op[i].t2 <= wake(entry_op[i].t2, cdb_en, cdb.tag);
		end
		// Dispatch slot is free, so the whole entry is overwritten
		if (disp_fire) begin
			entry_op[disp_slot] <= disp_op_byp;
		end
	end

endmodule

/* sources.f */
rtl/ooo_pkg.sv
rtl/rs.sv
rtl/exec_lanes.sv
rtl/ooo_issue_top.sv
dv/tb_clock_gen.sv
dv/ooo_issue_asserts.sv
dv/tb_ooo_issue.sv
